// File: bench/zclk_trace.txt
// five hex fields: op a b c d; op 1 write offset data resp bready_hold, 2 read offset data resp
// op 3 refresh pulse, 4 pins mask (10 iorq 08 dos_on 04 vdos_off 02 cpu 01 ide), 5 count cycles zpos zneg event
2 4 00000000 0 0
2 0 00000000 0 0
5 40 8 8 0
// 7 MHz requested, active only after refresh
1 0 00000001 0 0
2 0 00000001 0 0
2 4 00000100 0 0
5 40 8 8 0
3 0 0 0 0
2 4 00000001 0 0
5 40 10 10 0
// dos entry costs one 7 MHz tact
5 40 f f 1
5 40 10 10 0
// 14 MHz
1 0 00000002 0 0
2 4 00000101 0 0
5 40 10 10 0
3 0 0 0 0
2 4 00000002 0 0
5 40 20 20 0
// i/o event, nine frozen cycles
5 40 1b 1c 2
// held iorq, cpu and ide stalls
4 10 0 0 0
2 4 00000202 0 0
5 20 0 0 0
4 2 0 0 0
5 20 0 0 0
4 1 0 0 0
5 20 0 0 0
4 0 0 0 0
5 40 20 20 0
// bad writes and a bad read
1 4 00000003 2 0
2 4 00000002 0 0
1 c 00000001 2 0
2 0 00000002 0 0
2 8 00000000 2 0
// slow bready, then 2'b11 runs as 14 MHz
1 0 00000003 0 a
2 0 00000003 0 0
2 4 00000102 0 0
3 0 0 0 0
2 4 00000003 0 0
5 40 20 20 0
1 0 00000000 0 0
3 0 0 0 0
2 4 00000000 0 0
5 40 8 8 0
0 0 0 0 0

// File: files.f
rtl/zclk_pkg.sv
rtl/zclk_regs_pkg.sv
rtl/phase_gen.sv
rtl/turbo_ctrl.sv
rtl/wait_gen.sv
rtl/zclock.sv
rtl/zclk_csr.sv
rtl/zclk_top.sv
bench/tb_clkgen.sv
bench/zclk_tb.sv

// File: Bender.yml
package:
  name: zclk

sources:
  - files:
      - rtl/zclk_pkg.sv
      - rtl/zclk_regs_pkg.sv
      - rtl/phase_gen.sv
      - rtl/turbo_ctrl.sv
      - rtl/wait_gen.sv
      - rtl/zclock.sv
      - rtl/zclk_csr.sv
      - rtl/zclk_top.sv
  - target: test
    files:
      - bench/tb_clkgen.sv
      - bench/zclk_tb.sv

// File: bench/zclk_tb.sv
module zclk_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import zclk_regs_pkg::*;

	// each trace line holds an op and four argument words
	localparam int TRACE_LINES = 64;
	// two 3.5 MHz periods let any mode change settle
	localparam int SETTLE_CYCLES = 16;
	localparam int WAIT_LIMIT = 20;

	logic                   clk;
	logic                   rst_n;
	logic [AXIL_ADDR_W-1:0] awaddr;
	logic                   awvalid;
	logic                   awready;
	logic [AXIL_DATA_W-1:0] wdata;
	logic [AXIL_STRB_W-1:0] wstrb;
	logic                   wvalid;
	logic                   wready;
	logic [1:0]             bresp;
	logic                   bvalid;
	logic                   bready;
	logic [AXIL_ADDR_W-1:0] araddr;
	logic                   arvalid;
	logic                   arready;
	logic [AXIL_DATA_W-1:0] rdata;
	logic [1:0]             rresp;
	logic                   rvalid;
	logic                   rready;
	logic                   rfsh_n;
	logic                   iorq_s;
	logic                   dos_on;
	logic                   vdos_off;
	logic                   cpu_stall;
	logic                   ide_stall;
	logic                   zpos;
	logic                   zneg;
	logic                   zclk_out;

	logic [31:0] trace [0:TRACE_LINES*5-1];
	int          watchdog_cycles = 0;

	tb_clkgen clock_gen (.clk, .rst_n);

	zclk_top DUT (
		.clk, .rst_n,
		.awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
		.rfsh_n, .iorq_s, .dos_on, .vdos_off, .cpu_stall, .ide_stall,
		.zpos, .zneg, .zclk_out
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check_val(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
		begin
			abort_run($sformatf("mismatch at %0t ns: %s is 0x%0h, expected 0x%0h",
				$time, name, got, expected));
		end
	endtask

	// all driving and sampling happens 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic bus_write(input logic [31:0] offset, input logic [31:0] data,
		input logic [31:0] exp_resp, input logic [31:0] hold);
		int waited;
		awaddr = offset[AXIL_ADDR_W-1:0];
		wdata = data;
		wstrb = '1;
		awvalid = 1'b1;
		wvalid = 1'b1;
		bready = 1'b0;
		waited = 0;
		while (!(awready && wready))
		begin
			next_cycle();
			waited++;
			if (waited > WAIT_LIMIT)
				abort_run("write address and data were never accepted");
		end
		// handshake completes on the coming edge
		next_cycle();
		awvalid = 1'b0;
		wvalid = 1'b0;
		// the response has to stay put under back-pressure
		repeat (hold)
		begin
			check_val("bvalid under back-pressure", bvalid, 1);
			next_cycle();
		end
		bready = 1'b1;
		waited = 0;
		while (!bvalid)
		begin
			next_cycle();
			waited++;
			if (waited > WAIT_LIMIT)
				abort_run("write response never arrived");
		end
		check_val("bresp", bresp, exp_resp);
		next_cycle();
		bready = 1'b0;
		check_val("bvalid after response", bvalid, 0);
	endtask

	task automatic bus_read(input logic [31:0] offset, input logic [31:0] exp_data,
		input logic [31:0] exp_resp);
		int waited;
		araddr = offset[AXIL_ADDR_W-1:0];
		arvalid = 1'b1;
		rready = 1'b1;
		waited = 0;
		while (!arready)
		begin
			next_cycle();
			waited++;
			if (waited > WAIT_LIMIT)
				abort_run("read address was never accepted");
		end
		next_cycle();
		arvalid = 1'b0;
		waited = 0;
		while (!rvalid)
		begin
			next_cycle();
			waited++;
			if (waited > WAIT_LIMIT)
				abort_run("read data never arrived");
		end
		check_val($sformatf("rdata at offset %0h", offset), rdata, exp_data);
		check_val("rresp", rresp, exp_resp);
		next_cycle();
		rready = 1'b0;
		check_val("rvalid after response", rvalid, 0);
	endtask

	// the rising edge after two low cycles commits a new mode
	task automatic pulse_refresh();
		rfsh_n = 1'b0;
		repeat (2) next_cycle();
		rfsh_n = 1'b1;
		repeat (2) next_cycle();
	endtask

	task automatic set_pins(input logic [31:0] mask);
		iorq_s = mask[4];
		dos_on = mask[3];
		vdos_off = mask[2];
		cpu_stall = mask[1];
		ide_stall = mask[0];
		next_cycle();
	endtask

	// kind 1 fires a one-cycle dos event and kind 2 a one-cycle i/o event
	task automatic count_window(input logic [31:0] cycles, input logic [31:0] exp_pos,
		input logic [31:0] exp_neg, input logic [31:0] kind);
		int   n_pos;
		int   n_neg;
		int   waited;
		int   i;
		logic held_level;
		n_pos = 0;
		n_neg = 0;
		waited = 0;
		repeat (SETTLE_CYCLES) next_cycle();
		if (kind != 0)
		begin
			// line the event up with a zpos so the loss does not depend on phase
			while (!zpos)
			begin
				next_cycle();
				waited++;
				if (waited > SETTLE_CYCLES)
					abort_run("no zpos seen to line up the wait event");
			end
			if (kind == 1)
				dos_on = 1'b1;
			else
				iorq_s = 1'b1;
		end
		held_level = zclk_out;
		for (i = 0; i < cycles; i++)
		begin
			next_cycle();
			if (kind != 0 && i == 0)
			begin
				dos_on = 1'b0;
				iorq_s = 1'b0;
			end
			if (zpos)
				n_pos++;
			if (zneg)
				n_neg++;
			// a frozen clock must not move at all
			if (exp_pos == 0 && exp_neg == 0)
				check_val("zclk_out while stalled", zclk_out, held_level);
		end
		check_val("zpos count", n_pos, exp_pos);
		check_val("zneg count", n_neg, exp_neg);
	endtask

	initial
	begin
		wait (watchdog_cycles > 0);
		repeat (watchdog_cycles) @(posedge clk);
		abort_run("watchdog expired, the trace did not finish in time");
	end

	initial
	begin
		int          entry;
		int          budget;
		logic [31:0] op;
		logic [31:0] arg [0:3];
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		rfsh_n = 1'b1;
		iorq_s = 1'b0;
		dos_on = 1'b0;
		vdos_off = 1'b0;
		cpu_stall = 1'b0;
		ide_stall = 1'b0;
		for (entry = 0; entry < TRACE_LINES*5; entry++)
			trace[entry] = '0;
		$readmemh("bench/zclk_trace.txt", trace);
		// every window with its settle plus a fixed allowance per other operation
		budget = 50;
		for (entry = 0; entry < TRACE_LINES && trace[entry*5] != 0; entry++)
		begin
			if (trace[entry*5] == 5)
				budget += trace[entry*5+1] + 2*SETTLE_CYCLES;
			else
				budget += 50;
		end
		watchdog_cycles = budget;
		// still in reset here but past the first falling edge
		repeat (2) next_cycle();
		check_val("zpos in reset", zpos, 0);
		check_val("zneg in reset", zneg, 0);
		check_val("zclk_out in reset", zclk_out, 0);
		check_val("awready in reset", awready, 0);
		check_val("wready in reset", wready, 0);
		check_val("bvalid in reset", bvalid, 0);
		check_val("arready in reset", arready, 0);
		check_val("rvalid in reset", rvalid, 0);
		wait (rst_n);
		next_cycle();
		for (entry = 0; entry < TRACE_LINES && trace[entry*5] != 0; entry++)
		begin
			op = trace[entry*5];
			arg[0] = trace[entry*5+1];
			arg[1] = trace[entry*5+2];
			arg[2] = trace[entry*5+3];
			arg[3] = trace[entry*5+4];
			case (op)
				32'd1: bus_write(arg[0], arg[1], arg[2], arg[3]);
				32'd2: bus_read(arg[0], arg[1], arg[2]);
				32'd3: pulse_refresh();
				32'd4: set_pins(arg[0]);
				32'd5: count_window(arg[0], arg[1], arg[2], arg[3]);
				default: abort_run($sformatf("unknown operation %0h on trace line %0d",
					op, entry));
			endcase
		end
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// File: bench/tb_clkgen.sv
module tb_clkgen (
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	// 4 ns period, the 28 MHz system clock scaled for simulation
	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		// reset held for five rising edges, released just after the fifth
		repeat (5) @(posedge clk);
		#1 rst_n = 1'b1;
	end

	always #2 clk = ~clk;

endmodule

// File: rtl/zclk_top.sv
module zclk_top #(
	parameter zclk_pkg::turbo_t RESET_TURBO = zclk_pkg::TURBO_35
) (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic [zclk_regs_pkg::AXIL_ADDR_W-1:0] awaddr,
	input  logic                                 awvalid,
	output logic                                 awready,
	input  logic [zclk_regs_pkg::AXIL_DATA_W-1:0] wdata,
	input  logic [zclk_regs_pkg::AXIL_STRB_W-1:0] wstrb,
	input  logic                                 wvalid,
	output logic                                 wready,
	output logic [1:0]                           bresp,
	output logic                                 bvalid,
	input  logic                                 bready,
	input  logic [zclk_regs_pkg::AXIL_ADDR_W-1:0] araddr,
	input  logic                                 arvalid,
	output logic                                 arready,
	output logic [zclk_regs_pkg::AXIL_DATA_W-1:0] rdata,
	output logic [1:0]                           rresp,
	output logic                                 rvalid,
	input  logic                                 rready,
	input  logic                                 rfsh_n,
	input  logic                                 iorq_s,
	input  logic                                 dos_on,
	input  logic                                 vdos_off,
	input  logic                                 cpu_stall,
	input  logic                                 ide_stall,
	output logic                                 zpos,
	output logic                                 zneg,
	output logic                                 zclk_out
);
	import zclk_pkg::*;

	// host request and the mode actually in force
	turbo_t turbo_req;
	turbo_t turbo;
	logic   req_strobe;
	logic   pending;
	logic   io_wait;
	logic   stalling;
	logic   c0;
	logic   c2;

	zclk_csr #(.RESET_TURBO(RESET_TURBO)) u_csr (
		.clk, .rst_n,
		.awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
		.turbo, .pending, .stalling, .turbo_req, .req_strobe
	);

	turbo_ctrl #(.RESET_TURBO(RESET_TURBO)) u_turbo (
		.clk, .rst_n, .turbo_req, .req_strobe, .rfsh_n, .turbo, .pending
	);

	// c1 and c3 are not needed by the clock core
	phase_gen u_phase (
		.clk, .rst_n, .c0, .c1(), .c2, .c3()
	);

	wait_gen u_wait (
		.clk, .rst_n, .iorq_s, .dos_on, .vdos_off, .io_wait, .stalling
	);

	zclock u_zclock (
		.clk, .rst_n, .c0, .c2, .turbo, .io_wait, .cpu_stall, .ide_stall,
		.zpos, .zneg, .zclk_out
	);

endmodule

// File: rtl/zclk_csr.sv
module zclk_csr #(
	parameter zclk_pkg::turbo_t RESET_TURBO = zclk_pkg::TURBO_35
) (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic [zclk_regs_pkg::AXIL_ADDR_W-1:0] awaddr,
	input  logic                                 awvalid,
	output logic                                 awready,
	input  logic [zclk_regs_pkg::AXIL_DATA_W-1:0] wdata,
	input  logic [zclk_regs_pkg::AXIL_STRB_W-1:0] wstrb,
	input  logic                                 wvalid,
	output logic                                 wready,
	output logic [1:0]                           bresp,
	output logic                                 bvalid,
	input  logic                                 bready,
	input  logic [zclk_regs_pkg::AXIL_ADDR_W-1:0] araddr,
	input  logic                                 arvalid,
	output logic                                 arready,
	output logic [zclk_regs_pkg::AXIL_DATA_W-1:0] rdata,
	output logic [1:0]                           rresp,
	output logic                                 rvalid,
	input  logic                                 rready,
	input  zclk_pkg::turbo_t                     turbo,
	input  logic                                 pending,
	input  logic                                 stalling,
	output zclk_pkg::turbo_t                     turbo_req,
	output logic                                 req_strobe
);
	import zclk_pkg::*;
	import zclk_regs_pkg::*;

	turbo_t                 ctrl_q;
	logic                   wr_take;
	logic                   wr_hs;
	logic                   wr_ctrl;
	logic                   rd_take;
	logic                   rd_hs;
	logic [AXIL_DATA_W-1:0] status_word;
	logic [AXIL_DATA_W-1:0] rd_data_nxt;
	logic [1:0]             rd_resp_nxt;

	// raise both readies for one cycle once address and data are both present
	// nothing new is taken while the write response is still outstanding
	assign wr_take = awvalid & wvalid & ~bvalid & ~awready;
	assign wr_hs   = awready & awvalid & wvalid;
	assign wr_ctrl = (awaddr == REG_CTRL);

	// same scheme for reads, blocked while rdata waits for rready
	assign rd_take = arvalid & ~rvalid & ~arready;
	assign rd_hs   = arready & arvalid;

	// status is assembled from the live inputs
	always_comb
	begin
		status_word = '0;
		status_word[1:0] = turbo;
		status_word[STATUS_PENDING_BIT] = pending;
		status_word[STATUS_STALL_BIT] = stalling;
	end

	// read decode, unknown offsets read as zero with slverr
	always_comb
	begin
		rd_data_nxt = '0;
		rd_resp_nxt = RESP_OKAY;
		if (araddr == REG_CTRL)
			rd_data_nxt[1:0] = ctrl_q;
		else if (araddr == REG_STATUS)
			rd_data_nxt = status_word;
		else
			rd_resp_nxt = RESP_SLVERR;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			awready    <= 1'b0;
			wready     <= 1'b0;
			bvalid     <= 1'b0;
			arready    <= 1'b0;
			rvalid     <= 1'b0;
			ctrl_q     <= RESET_TURBO;
			req_strobe <= 1'b0;
		end
		else
		begin
			awready    <= wr_take;
			wready     <= wr_take;
			arready    <= rd_take;
			req_strobe <= 1'b0;
			if (wr_hs)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
			if (rd_hs)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
			// only byte 0 carries the request, it reaches turbo_ctrl with bvalid
			if (wr_hs && wr_ctrl && wstrb[0])
			begin
				ctrl_q     <= turbo_t'(wdata[1:0]);
				req_strobe <= 1'b1;
			end
		end
	end

	// response payload, only meaningful while the matching valid is high
	always_ff @(posedge clk)
	begin
		if (wr_hs)
			bresp <= wr_ctrl ? RESP_OKAY : RESP_SLVERR;
		if (rd_hs)
		begin
			rdata <= rd_data_nxt;
			rresp <= rd_resp_nxt;
		end
	end

	assign turbo_req = ctrl_q;

endmodule

// File: rtl/zclock.sv
module zclock (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             c0,
	input  logic             c2,
	input  zclk_pkg::turbo_t turbo,
	input  logic             io_wait,
	input  logic             cpu_stall,
	input  logic             ide_stall,
	output logic             zpos,
	output logic             zneg,
	output logic             zclk_out
);
	import zclk_pkg::*;

	logic stall;
	// 14 MHz source, toggles every system cycle unless stalled
	logic clk14_src;
	// picks every other c2 for 3.5 MHz
	logic c2_cnt;
	logic pre_zpos;
	logic pre_zneg;

	// any stall source freezes the cpu clock
	assign stall = cpu_stall | ide_stall | io_wait;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			clk14_src <= 1'b0;
		else if (!stall)
			clk14_src <= ~clk14_src;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			c2_cnt <= 1'b0;
		else if (c2)
			c2_cnt <= ~c2_cnt;
	end

	// pre-strobes per mode
	// 3.5 MHz alternates zpos and zneg on successive c2
	always_comb
	begin
		case (turbo)
			TURBO_35:
			begin
				pre_zpos = c2_cnt & c2;
				pre_zneg = ~c2_cnt & c2;
			end
			TURBO_70:
			begin
				pre_zpos = c2;
				pre_zneg = c0;
			end
			// 14 MHz, also taken for the 2'b11 encoding
			default:
			begin
				pre_zpos = clk14_src;
				pre_zneg = ~clk14_src;
			end
		endcase
	end

	// a strobe only fires when it would actually flip the clock
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			zpos <= 1'b0;
			zneg <= 1'b0;
		end
		else
		begin
			zpos <= ~stall & pre_zpos & zclk_out;
			zneg <= ~stall & pre_zneg & ~zclk_out;
		end
	end

	// cpu clock moves half a system cycle after its strobe
	// the board inverts this pin, so zpos drives it low
	always_ff @(negedge clk or negedge rst_n)
	begin
		if (!rst_n)
			zclk_out <= 1'b0;
		else if (zpos)
			zclk_out <= 1'b0;
		else if (zneg)
			zclk_out <= 1'b1;
	end

endmodule

// File: rtl/wait_gen.sv
module wait_gen (
	input  logic clk,
	input  logic rst_n,
	input  logic iorq_s,
	input  logic dos_on,
	input  logic vdos_off,
	output logic io_wait,
	output logic stalling
);
	import zclk_pkg::*;

	// stretch counter parked at all ones when idle
	logic [STALL_CNT_W-1:0] stall_cnt;
	logic                   dos_evt;
	logic                   cnt_done;

	// dos space entered or left
	assign dos_evt  = dos_on | vdos_off;
	// counting ends once the top bit is set
	assign cnt_done = stall_cnt[STALL_CNT_W-1];

	// a dos event wins over an i/o event in the same cycle
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			stall_cnt <= '1;
		else if (dos_evt)
			stall_cnt <= DOS_STALL_START;
		else if (iorq_s)
			stall_cnt <= IO_STALL_START;
		else if (!cnt_done)
			stall_cnt <= stall_cnt + 1'b1;
	end

	// a stall starts with its trigger and lasts until the count ends
	assign io_wait = dos_evt | iorq_s | ~cnt_done;

	// registered copy for the status register
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			stalling <= 1'b0;
		else
			stalling <= io_wait;
	end

endmodule

// File: rtl/turbo_ctrl.sv
module turbo_ctrl #(
	parameter zclk_pkg::turbo_t RESET_TURBO = zclk_pkg::TURBO_35
) (
	input  logic             clk,
	input  logic             rst_n,
	input  zclk_pkg::turbo_t turbo_req,
	input  logic             req_strobe,
	input  logic             rfsh_n,
	output zclk_pkg::turbo_t turbo,
	output logic             pending
);
	import zclk_pkg::*;

	// request held until the next refresh
	turbo_t req_q;
	// previous refresh level, for edge detection
	logic   rfsh_q;
	logic   rfsh_rise;

	// refresh going inactive is the only safe point to change the rate
	assign rfsh_rise = rfsh_n & ~rfsh_q;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			req_q   <= RESET_TURBO;
			rfsh_q  <= 1'b1;
			turbo   <= RESET_TURBO;
			pending <= 1'b0;
		end
		else
		begin
			rfsh_q <= rfsh_n;
			if (req_strobe)
				req_q <= turbo_req;
			if (rfsh_rise)
			begin
				// a request arriving in the same cycle goes straight through
				turbo   <= req_strobe ? turbo_req : req_q;
				pending <= 1'b0;
			end
			else if (req_strobe)
				pending <= 1'b1;
		end
	end

endmodule

// File: rtl/phase_gen.sv
module phase_gen (
	input  logic clk,
	input  logic rst_n,
	output logic c0,
	output logic c1,
	output logic c2,
	output logic c3
);
	import zclk_pkg::*;

	// free running step counter, wraps every four system cycles
	logic [PHASE_W-1:0] phase;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			phase <= '0;
		else
			phase <= phase + 1'b1;
	end

	// one strobe per step, each high for a single cycle
	// c2 is the positive step and c0 the negative step at 7 MHz
	assign c0 = (phase == PHASE_W'(0));
	assign c1 = (phase == PHASE_W'(1));
	assign c2 = (phase == PHASE_W'(2));
	assign c3 = (phase == PHASE_W'(3));

	// c1 and c3 serve other bus timing in the full system

endmodule

// File: rtl/zclk_regs_pkg.sv
package zclk_regs_pkg;

	// axi4-lite bus widths
	localparam int AXIL_ADDR_W = 4;
	localparam int AXIL_DATA_W = 32;
	localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

	// register offsets
	// ctrl bits [1:0] hold the turbo request
	localparam logic [AXIL_ADDR_W-1:0] REG_CTRL   = 4'h0;
	// status is read only: [1:0] active mode, 8 change pending, 9 stall in progress
	localparam logic [AXIL_ADDR_W-1:0] REG_STATUS = 4'h4;

	localparam int STATUS_PENDING_BIT = 8;
	localparam int STATUS_STALL_BIT   = 9;

	// response codes
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// File: rtl/zclk_pkg.sv
package zclk_pkg;

	// cpu clock rate selection, as held in the ctrl register and in turbo_ctrl
	// 2'b11 is not named here, the clock core treats it like TURBO_140
	typedef enum logic [1:0]
	{
		TURBO_35  = 2'b00,
		TURBO_70  = 2'b01,
		TURBO_140 = 2'b10
	} turbo_t;

	// width of the wait stretch counter
	// the top bit set means the count has ended
	localparam int STALL_CNT_W = 4;

	// dos entry or exit: counts 4..7, four 28 MHz tacts (one 7 MHz tact)
	localparam logic [STALL_CNT_W-1:0] DOS_STALL_START = 4'd4;

	// i/o cycle: counts 0..7, eight 28 MHz tacts (one 3.5 MHz tact)
	localparam logic [STALL_CNT_W-1:0] IO_STALL_START = 4'd0;

	// the 28 MHz system clock is split into four steps per 7 MHz period
	// c0..c3 are decoded from a counter of this width
	localparam int PHASE_W = 2;

endpackage
